// ==== hw/de1_io_pkg.sv ====
package de1_io_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus geometry
	//////////////////////////////////////////////////////////////////////

	// Host data word
	localparam int BUS_WIDTH  = 32;
	// Eight registers in the PIO window
	localparam int ADDR_WIDTH = 3;

	//////////////////////////////////////////////////////////////////////
	// Seven-segment displays
	//////////////////////////////////////////////////////////////////////

	// HEX0 through HEX5 on the board
	localparam int HEX_DIGITS     = 6;
	// Segments a..g, bit 0 is segment a
	localparam int SEG_WIDTH      = 7;
	// One byte slot per digit in the register map
	localparam int HEX_BYTE_WIDTH = 8;
	// HEX3..HEX0 share the first display register
	localparam int HEX_LO_DIGITS  = 4;

	typedef logic [BUS_WIDTH-1:0] bus_data_t;

	//////////////////////////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [ADDR_WIDTH-1:0] {
		// LED pattern, rw
		ADDR_LEDR      = 3'd0,
		// Display bytes for HEX3..HEX0, rw
		ADDR_HEX3_HEX0 = 3'd1,
		// Display bytes for HEX5..HEX4, rw
		ADDR_HEX5_HEX4 = 3'd2,
		// Synchronized switches, ro
		ADDR_SW        = 3'd3,
		// Keys held down right now, ro
		ADDR_KEY_DATA  = 3'd4,
		// Interrupt enables per key, rw
		ADDR_KEY_MASK  = 3'd5,
		// Press capture, write 1 to clear
		ADDR_KEY_EDGE  = 3'd6,
		// Per-digit hex decode enable, rw
		ADDR_HEX_MODE  = 3'd7
	} pio_addr_e;

	// One bus request, single-cycle strobes
	typedef struct packed {
		logic      wr;
		logic      rd;
		pio_addr_e addr;
		bus_data_t wdata;
	} pio_req_t;

endpackage

// ==== hw/board_input_sync.sv ====
`timescale 1ns/100ps

module board_input_sync #(
	parameter int SW_WIDTH  = 10,
	parameter int KEY_WIDTH = 4
) (
	input  logic                 clock_50,
	input  logic                 rst,

	// Raw board pins
	input  logic [SW_WIDTH-1:0]  sw,
	input  logic [KEY_WIDTH-1:0] key_n,

	// Write-one-to-clear pulse from the register block
	input  logic [KEY_WIDTH-1:0] edge_clear,

	output logic [SW_WIDTH-1:0]  sw_sync,
	output logic [KEY_WIDTH-1:0] key_pressed,
	output logic [KEY_WIDTH-1:0] key_edge
);

	//////////////////////////////////////////////////////////////////////
	// Synchronizer chains
	//////////////////////////////////////////////////////////////////////

	// First stage, may go metastable
	logic [SW_WIDTH-1:0]  sw_meta;
	logic [KEY_WIDTH-1:0] key_meta;

	// Last cycle's pressed state, for edge detect
	logic [KEY_WIDTH-1:0] key_prev;

	// Single-cycle press indication
	logic [KEY_WIDTH-1:0] key_rise;

	always_ff @(posedge clock_50) begin
		if (rst) begin
			sw_meta     <= '0;
			sw_sync     <= '0;
			// Released keys read as 0 after inversion
			key_meta    <= '0;
			key_pressed <= '0;
			key_prev    <= '0;
		end else begin
			// Switches, two flops
			sw_meta     <= sw;
			sw_sync     <= sw_meta;

			// Keys are active low on the board
			key_meta    <= ~key_n;
			key_pressed <= key_meta;

			// Third stage only feeds the edge detector
			key_prev    <= key_pressed;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Edge capture
	//////////////////////////////////////////////////////////////////////

	// Press = 0 -> 1 on the synchronized key
	assign key_rise = key_pressed & ~key_prev;

	// Sticky bits; a new press beats a clear in the same cycle
	always_ff @(posedge clock_50) begin
		if (rst) begin
			key_edge <= '0;
		end else begin
			key_edge <= (key_edge & ~edge_clear) | key_rise;
		end
	end

endmodule

// ==== hw/pio_regs.sv ====
`timescale 1ns/100ps

module pio_regs import de1_io_pkg::*; #(
	parameter int SW_WIDTH  = 10,
	parameter int LED_WIDTH = 10,
	parameter int KEY_WIDTH = 4
) (
	input  logic                                  clock_50,
	input  logic                                  rst,

	// Host bus
	input  pio_req_t                              req,

	// From the input synchronizer
	input  logic [SW_WIDTH-1:0]                   sw_sync,
	input  logic [KEY_WIDTH-1:0]                  key_pressed,
	input  logic [KEY_WIDTH-1:0]                  key_edge,

	// Read return, one cycle after the strobe
	output bus_data_t                             rdata,
	output logic                                  rdata_valid,

	// Board-facing register contents
	output logic [LED_WIDTH-1:0]                  led_q,
	output logic [HEX_DIGITS*HEX_BYTE_WIDTH-1:0]  hex_raw,
	output logic [HEX_DIGITS-1:0]                 hex_mode,

	// Capture clear and interrupt
	output logic [KEY_WIDTH-1:0]                  edge_clear,
	output logic                                  irq
);

	// Display register split
	localparam int HEX_BITS = HEX_DIGITS * HEX_BYTE_WIDTH;
	localparam int LO_BITS  = HEX_LO_DIGITS * HEX_BYTE_WIDTH;
	localparam int HI_BITS  = HEX_BITS - LO_BITS;

	// Interrupt enables
	logic [KEY_WIDTH-1:0] key_mask;

	// Per-register write enables
	logic wr_ledr;
	logic wr_hex_lo;
	logic wr_hex_hi;
	logic wr_mask;
	logic wr_edge;
	logic wr_mode;

	// Read mux result before the output flop
	bus_data_t rdata_d;

	//////////////////////////////////////////////////////////////////////
	// Write decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		wr_ledr   = 1'b0;
		wr_hex_lo = 1'b0;
		wr_hex_hi = 1'b0;
		wr_mask   = 1'b0;
		wr_edge   = 1'b0;
		wr_mode   = 1'b0;
		if (req.wr) begin
			case (req.addr)
				ADDR_LEDR:      wr_ledr   = 1'b1;
				ADDR_HEX3_HEX0: wr_hex_lo = 1'b1;
				ADDR_HEX5_HEX4: wr_hex_hi = 1'b1;
				ADDR_KEY_MASK:  wr_mask   = 1'b1;
				ADDR_KEY_EDGE:  wr_edge   = 1'b1;
				ADDR_HEX_MODE:  wr_mode   = 1'b1;
				// SW and KEY_DATA are read only
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Writable registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_50) begin
		if (rst) begin
			led_q    <= '0;
			hex_raw  <= '0;
			hex_mode <= '0;
			key_mask <= '0;
		end else begin
			if (wr_ledr)
				led_q <= req.wdata[LED_WIDTH-1:0];
			// Full bytes kept, bit 7 is spare
			if (wr_hex_lo)
				hex_raw[LO_BITS-1:0] <= req.wdata[LO_BITS-1:0];
			if (wr_hex_hi)
				hex_raw[HEX_BITS-1:LO_BITS] <= req.wdata[HI_BITS-1:0];
			if (wr_mode)
				hex_mode <= req.wdata[HEX_DIGITS-1:0];
			if (wr_mask)
				key_mask <= req.wdata[KEY_WIDTH-1:0];
		end
	end

	// Clear lands in the capture register on the write edge itself
	assign edge_clear = wr_edge ? req.wdata[KEY_WIDTH-1:0] : '0;

	// Level interrupt, any enabled capture bit
	assign irq = |(key_edge & key_mask);

	//////////////////////////////////////////////////////////////////////
	// Read path
	//////////////////////////////////////////////////////////////////////

	// Zero-extended select
	always_comb begin
		rdata_d = '0;
		case (req.addr)
			ADDR_LEDR:      rdata_d[LED_WIDTH-1:0]  = led_q;
			ADDR_HEX3_HEX0: rdata_d[LO_BITS-1:0]    = hex_raw[LO_BITS-1:0];
			ADDR_HEX5_HEX4: rdata_d[HI_BITS-1:0]    = hex_raw[HEX_BITS-1:LO_BITS];
			ADDR_SW:        rdata_d[SW_WIDTH-1:0]   = sw_sync;
			ADDR_KEY_DATA:  rdata_d[KEY_WIDTH-1:0]  = key_pressed;
			ADDR_KEY_MASK:  rdata_d[KEY_WIDTH-1:0]  = key_mask;
			ADDR_KEY_EDGE:  rdata_d[KEY_WIDTH-1:0]  = key_edge;
			ADDR_HEX_MODE:  rdata_d[HEX_DIGITS-1:0] = hex_mode;
			default: ;
		endcase
	end

	// Valid pulse, one cycle per strobe
	always_ff @(posedge clock_50) begin
		if (rst)
			rdata_valid <= 1'b0;
		else
			rdata_valid <= req.rd;
	end

	// Data holds until the next read
	always_ff @(posedge clock_50) begin
		if (req.rd)
			rdata <= rdata_d;
	end

endmodule

// ==== hw/hex_display_drive.sv ====
`timescale 1ns/100ps

module hex_display_drive import de1_io_pkg::*; (
	input  logic                                 clock_50,
	input  logic                                 rst,

	// One byte per digit, segments in bits 6..0
	input  logic [HEX_DIGITS*HEX_BYTE_WIDTH-1:0] hex_raw,
	// 1 = decode low nibble, 0 = raw segments
	input  logic [HEX_DIGITS-1:0]                hex_mode,

	// Active-low segment pins
	output logic [SEG_WIDTH-1:0]                 hex0,
	output logic [SEG_WIDTH-1:0]                 hex1,
	output logic [SEG_WIDTH-1:0]                 hex2,
	output logic [SEG_WIDTH-1:0]                 hex3,
	output logic [SEG_WIDTH-1:0]                 hex4,
	output logic [SEG_WIDTH-1:0]                 hex5
);

	//////////////////////////////////////////////////////////////////////
	// Nibble to segment table, 1 = lit
	//////////////////////////////////////////////////////////////////////

	function automatic logic [SEG_WIDTH-1:0] seg_decode(input logic [3:0] nibble);
		logic [SEG_WIDTH-1:0] seg;
		case (nibble)
			4'h0:    seg = 7'h3f;
			4'h1:    seg = 7'h06;
			4'h2:    seg = 7'h5b;
			4'h3:    seg = 7'h4f;
			4'h4:    seg = 7'h66;
			4'h5:    seg = 7'h6d;
			4'h6:    seg = 7'h7d;
			4'h7:    seg = 7'h07;
			4'h8:    seg = 7'h7f;
			4'h9:    seg = 7'h6f;
			// Letters, lower case b and d
			4'ha:    seg = 7'h77;
			4'hb:    seg = 7'h7c;
			4'hc:    seg = 7'h39;
			4'hd:    seg = 7'h5e;
			4'he:    seg = 7'h79;
			default: seg = 7'h71;
		endcase
		return seg;
	endfunction

	// Pattern before inversion
	logic [SEG_WIDTH-1:0] seg_lit [HEX_DIGITS];
	// Registered pin values
	logic [SEG_WIDTH-1:0] seg_q   [HEX_DIGITS];

	// Mode select per digit
	always_comb begin
		for (int i = 0; i < HEX_DIGITS; i++) begin
			if (hex_mode[i])
				seg_lit[i] = seg_decode(hex_raw[i*HEX_BYTE_WIDTH +: 4]);
			else
				seg_lit[i] = hex_raw[i*HEX_BYTE_WIDTH +: SEG_WIDTH];
		end
	end

	// Board segments are active low; all ones = blank
	always_ff @(posedge clock_50) begin
		if (rst) begin
			for (int i = 0; i < HEX_DIGITS; i++)
				seg_q[i] <= '1;
		end else begin
			for (int i = 0; i < HEX_DIGITS; i++)
				seg_q[i] <= ~seg_lit[i];
		end
	end

	assign hex0 = seg_q[0];
	assign hex1 = seg_q[1];
	assign hex2 = seg_q[2];
	assign hex3 = seg_q[3];
	assign hex4 = seg_q[4];
	assign hex5 = seg_q[5];

endmodule

// ==== hw/de1_io_system.sv ====
`timescale 1ns/100ps

module de1_io_system import de1_io_pkg::*; #(
	parameter int SW_WIDTH  = 10,
	parameter int LED_WIDTH = 10,
	parameter int KEY_WIDTH = 4
) (
	input  logic                 clock_50,
	input  logic                 rst,

	// Host bus
	input  pio_req_t             req,
	output bus_data_t            rdata,
	output logic                 rdata_valid,

	// Board pins
	input  logic [SW_WIDTH-1:0]  sw,
	input  logic [KEY_WIDTH-1:0] key_n,
	output logic [LED_WIDTH-1:0] ledr,
	output logic                 irq,
	output logic [SEG_WIDTH-1:0] hex0,
	output logic [SEG_WIDTH-1:0] hex1,
	output logic [SEG_WIDTH-1:0] hex2,
	output logic [SEG_WIDTH-1:0] hex3,
	output logic [SEG_WIDTH-1:0] hex4,
	output logic [SEG_WIDTH-1:0] hex5
);

	// Synchronizer to register block
	logic [SW_WIDTH-1:0]                  sw_sync;
	logic [KEY_WIDTH-1:0]                 key_pressed;
	logic [KEY_WIDTH-1:0]                 key_edge;
	// Register block back to the synchronizer
	logic [KEY_WIDTH-1:0]                 edge_clear;
	// Register block to display driver
	logic [HEX_DIGITS*HEX_BYTE_WIDTH-1:0] hex_raw;
	logic [HEX_DIGITS-1:0]                hex_mode;

	//////////////////////////////////////////////////////////////////////
	// Switches and pushbuttons
	//////////////////////////////////////////////////////////////////////

	board_input_sync #(
		.SW_WIDTH   (SW_WIDTH),
		.KEY_WIDTH  (KEY_WIDTH)
	) input_sync_i (
		.clock_50   (clock_50),
		.rst        (rst),
		.sw         (sw),
		.key_n      (key_n),
		.edge_clear (edge_clear),
		.sw_sync    (sw_sync),
		.key_pressed(key_pressed),
		.key_edge   (key_edge)
	);

	//////////////////////////////////////////////////////////////////////
	// PIO registers, LEDs straight to the pins
	//////////////////////////////////////////////////////////////////////

	pio_regs #(
		.SW_WIDTH   (SW_WIDTH),
		.LED_WIDTH  (LED_WIDTH),
		.KEY_WIDTH  (KEY_WIDTH)
	) regs_i (
		.clock_50   (clock_50),
		.rst        (rst),
		.req        (req),
		.sw_sync    (sw_sync),
		.key_pressed(key_pressed),
		.key_edge   (key_edge),
		.rdata      (rdata),
		.rdata_valid(rdata_valid),
		.led_q      (ledr),
		.hex_raw    (hex_raw),
		.hex_mode   (hex_mode),
		.edge_clear (edge_clear),
		.irq        (irq)
	);

	// Display pins, one cycle behind the registers
	hex_display_drive hex_drive_i (
		.clock_50   (clock_50),
		.rst        (rst),
		.hex_raw    (hex_raw),
		.hex_mode   (hex_mode),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2),
		.hex3       (hex3),
		.hex4       (hex4),
		.hex5       (hex5)
	);

endmodule

// ==== dv/de1_io_assert.sv ====
`timescale 1ns/100ps

module de1_io_assert import de1_io_pkg::*; #(
	parameter int LED_WIDTH = 10,
	parameter int KEY_WIDTH = 4
) (
	input logic                            clock_50,
	input logic                            rst,
	input pio_req_t                        req,
	input logic                            rdata_valid,
	input logic [LED_WIDTH-1:0]            ledr,
	input logic                            irq,
	// Capture register inside the top level
	input logic [KEY_WIDTH-1:0]            key_edge,
	// hex5..hex0, hex0 in the low bits
	input logic [HEX_DIGITS*SEG_WIDTH-1:0] hex_all
);

	// Failed assertions so far, watched by the testbench
	int fail_count = 0;

	// Interrupt enables as last written on the bus
	logic [KEY_WIDTH-1:0] mask_q;
	// Write-one-to-clear request this cycle
	logic [KEY_WIDTH-1:0] clear_req;

	always_ff @(posedge clock_50) begin
		if (rst)
			mask_q <= '0;
		else if (req.wr && req.addr == ADDR_KEY_MASK)
			mask_q <= req.wdata[KEY_WIDTH-1:0];
	end

	assign clear_req = (req.wr && req.addr == ADDR_KEY_EDGE) ? req.wdata[KEY_WIDTH-1:0] : '0;

	//////////////////////////////////////////////////////////////////////
	// Reset and bus timing
	//////////////////////////////////////////////////////////////////////

	// Blank displays, LEDs off, no pulses
	reset_values: assert property (@(posedge clock_50)
		rst |=> (ledr == '0 && !irq && !rdata_valid && hex_all == '1))
		else begin
			fail_count++;
			$error("Outputs not at their reset values after reset");
		end

	// One valid per strobe, fixed latency
	read_latency: assert property (@(posedge clock_50) disable iff (rst)
		rdata_valid == $past(req.rd))
		else begin
			fail_count++;
			$error("rdata_valid does not follow the read strobe by one cycle");
		end

	led_write: assert property (@(posedge clock_50) disable iff (rst)
		(req.wr && req.addr == ADDR_LEDR) |=> ledr == $past(req.wdata[LED_WIDTH-1:0]))
		else begin
			fail_count++;
			$error("ledr did not take the written LED value");
		end

	//////////////////////////////////////////////////////////////////////
	// Key capture and interrupt
	//////////////////////////////////////////////////////////////////////

	// Sticky until written with a 1
	edge_sticky: assert property (@(posedge clock_50) disable iff (rst)
		($past(key_edge) & ~key_edge & ~$past(clear_req)) == '0)
		else begin
			fail_count++;
			$error("Capture bit cleared without a clear write");
		end

	irq_level: assert property (@(posedge clock_50) disable iff (rst)
		irq == |(key_edge & mask_q))
		else begin
			fail_count++;
			$error("irq differs from the masked capture bits");
		end

endmodule

// Attach to every instance of the top level
bind de1_io_system de1_io_assert #(
	.LED_WIDTH  (LED_WIDTH),
	.KEY_WIDTH  (KEY_WIDTH)
) assert_i (
	.clock_50   (clock_50),
	.rst        (rst),
	.req        (req),
	.rdata_valid(rdata_valid),
	.ledr       (ledr),
	.irq        (irq),
	.key_edge   (key_edge),
	.hex_all    ({hex5, hex4, hex3, hex2, hex1, hex0})
);

// ==== dv/tb_de1_io_system.sv ====
`timescale 1ns/100ps

module tb_de1_io_system import de1_io_pkg::*; ();

	localparam int SW_WIDTH    = 10;
	localparam int LED_WIDTH   = 10;
	localparam int KEY_WIDTH   = 4;
	localparam int HEX_BITS    = HEX_DIGITS * HEX_BYTE_WIDTH;
	// Bus operations in the run
	localparam int NUM_OPS     = 131;
	// 20 cycles per operation plus margin
	localparam int WATCHDOG_NS = (NUM_OPS * 20 + 200) * 10;

	logic                           clock_50;
	logic                           rst;
	pio_req_t                       req;
	logic [SW_WIDTH-1:0]            sw;
	logic [KEY_WIDTH-1:0]           key_n;
	bus_data_t                      rdata;
	logic                           rdata_valid;
	logic [LED_WIDTH-1:0]           ledr;
	logic                           irq;
	// hex5..hex0 with hex0 in the low bits
	wire [HEX_DIGITS*SEG_WIDTH-1:0] hex_pins;

	// Expected register contents
	logic [LED_WIDTH-1:0]           led_m;
	logic [HEX_BITS-1:0]            hex_m;
	logic [HEX_DIGITS-1:0]          mode_m;
	logic [KEY_WIDTH-1:0]           mask_m;
	logic [KEY_WIDTH-1:0]           edge_m;
	logic [HEX_BITS-1:0]            digits;

	// Standard 0-F segment patterns with 1 = lit and bit 0 as segment a
	logic [SEG_WIDTH-1:0] seg_table [16] = '{
		7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
		7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
	};

	de1_io_system dut_i (
		.clock_50   (clock_50),
		.rst        (rst),
		.req        (req),
		.rdata      (rdata),
		.rdata_valid(rdata_valid),
		.sw         (sw),
		.key_n      (key_n),
		.ledr       (ledr),
		.irq        (irq),
		.hex0       (hex_pins[0*SEG_WIDTH +: SEG_WIDTH]),
		.hex1       (hex_pins[1*SEG_WIDTH +: SEG_WIDTH]),
		.hex2       (hex_pins[2*SEG_WIDTH +: SEG_WIDTH]),
		.hex3       (hex_pins[3*SEG_WIDTH +: SEG_WIDTH]),
		.hex4       (hex_pins[4*SEG_WIDTH +: SEG_WIDTH]),
		.hex5       (hex_pins[5*SEG_WIDTH +: SEG_WIDTH])
	);

	initial begin
		clock_50 = 1'b0;
		forever #5 clock_50 = ~clock_50;
	end

	//////////////////////////////////////////////////////////////////////
	// Failure and bus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input bus_data_t got, input bus_data_t exp);
		$display("[FAIL] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
		stop_run();
	endtask

	// Register map view of the model
	function automatic bus_data_t expected_read(input pio_addr_e addr);
		bus_data_t exp;
		exp = '0;
		case (addr)
			ADDR_LEDR:      exp[LED_WIDTH-1:0] = led_m;
			ADDR_HEX3_HEX0: exp = hex_m[31:0];
			ADDR_HEX5_HEX4: exp[15:0] = hex_m[HEX_BITS-1:32];
			ADDR_SW:        exp[SW_WIDTH-1:0] = sw;
			ADDR_KEY_DATA:  exp[KEY_WIDTH-1:0] = ~key_n;
			ADDR_KEY_MASK:  exp[KEY_WIDTH-1:0] = mask_m;
			ADDR_KEY_EDGE:  exp[KEY_WIDTH-1:0] = edge_m;
			default:        exp[HEX_DIGITS-1:0] = mode_m;
		endcase
		return exp;
	endfunction

	task automatic write_reg(input pio_addr_e addr, input bus_data_t data);
		@(negedge clock_50);
		req = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
		@(negedge clock_50);
		req = '0;
		case (addr)
			ADDR_LEDR:      led_m = data[LED_WIDTH-1:0];
			ADDR_HEX3_HEX0: hex_m[31:0] = data;
			ADDR_HEX5_HEX4: hex_m[HEX_BITS-1:32] = data[15:0];
			ADDR_KEY_MASK:  mask_m = data[KEY_WIDTH-1:0];
			ADDR_KEY_EDGE:  edge_m = edge_m & ~data[KEY_WIDTH-1:0];
			ADDR_HEX_MODE:  mode_m = data[HEX_DIGITS-1:0];
			default: ;
		endcase
	endtask

	// Response is due one edge after the strobe
	task automatic read_reg(input pio_addr_e addr);
		bus_data_t exp;
		exp = expected_read(addr);
		@(negedge clock_50);
		req = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: '0};
		@(negedge clock_50);
		req = '0;
		if (!rdata_valid) begin
			$display("No read response one cycle after the read of address %0d", addr);
			stop_run();
		end else if (rdata !== exp) begin
			report_mismatch("rdata", rdata, exp);
		end
	endtask

	// Display pins lag the registers by one cycle
	task automatic check_pins();
		logic [HEX_BYTE_WIDTH-1:0] digit_byte;
		logic [SEG_WIDTH-1:0]      exp_seg;
		@(negedge clock_50);
		if (ledr !== led_m)
			report_mismatch("ledr", ledr, led_m);
		for (int i = 0; i < HEX_DIGITS; i++) begin
			digit_byte = hex_m[i*HEX_BYTE_WIDTH +: HEX_BYTE_WIDTH];
			exp_seg = mode_m[i] ? ~seg_table[digit_byte[3:0]] : ~digit_byte[SEG_WIDTH-1:0];
			if (hex_pins[i*SEG_WIDTH +: SEG_WIDTH] !== exp_seg)
				report_mismatch($sformatf("hex%0d", i), hex_pins[i*SEG_WIDTH +: SEG_WIDTH],
					exp_seg);
		end
	endtask

	// Hold a key past the synchronizer and then let go
	task automatic press_key(input int k);
		@(negedge clock_50);
		key_n[k] = 1'b0;
		repeat (4) @(negedge clock_50);
		edge_m[k] = 1'b1;
		read_reg(ADDR_KEY_DATA);
		read_reg(ADDR_KEY_EDGE);
		key_n[k] = 1'b1;
		repeat (4) @(negedge clock_50);
		read_reg(ADDR_KEY_EDGE);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hfa6c));
		rst    = 1'b1;
		req    = '0;
		sw     = '0;
		key_n  = '1;
		led_m  = '0;
		hex_m  = '0;
		mode_m = '0;
		mask_m = '0;
		edge_m = '0;
		digits = '0;
		repeat (2) @(negedge clock_50);
		rst = 1'b0;

		// Reset values on pins and in every register
		check_pins();
		for (int a = 0; a < 8; a++)
			read_reg(pio_addr_e'(a));

		// Raw mode write-back
		repeat (8) begin
			write_reg(ADDR_LEDR, $urandom);
			write_reg(ADDR_HEX3_HEX0, $urandom);
			write_reg(ADDR_HEX5_HEX4, $urandom);
			check_pins();
			read_reg(ADDR_LEDR);
			read_reg(ADDR_HEX3_HEX0);
			read_reg(ADDR_HEX5_HEX4);
		end

		// Hex decode of every nibble on every digit
		write_reg(ADDR_HEX_MODE, 32'h3f);
		read_reg(ADDR_HEX_MODE);
		for (int n = 0; n < 16; n++) begin
			// Random upper nibbles that decode must ignore
			digits = {16'($urandom), $urandom};
			for (int i = 0; i < HEX_DIGITS; i++)
				digits[i*HEX_BYTE_WIDTH +: 4] = 4'(n + i);
			write_reg(ADDR_HEX3_HEX0, digits[31:0]);
			write_reg(ADDR_HEX5_HEX4, 32'(digits[HEX_BITS-1:32]));
			check_pins();
		end
		// Mixed raw and decoded digits
		write_reg(ADDR_HEX_MODE, 32'h15);
		check_pins();

		// Switch reads after the two-flop delay
		repeat (6) begin
			@(negedge clock_50);
			sw = SW_WIDTH'($urandom);
			repeat (2) @(negedge clock_50);
			read_reg(ADDR_SW);
		end
		// Read-only write must change neither the switches nor the pins
		write_reg(ADDR_SW, 32'(~sw));
		read_reg(ADDR_SW);
		check_pins();

		// Capture and clear of each key with interrupts disabled
		for (int k = 0; k < KEY_WIDTH; k++) begin
			press_key(k);
			write_reg(ADDR_KEY_EDGE, 1 << k);
			read_reg(ADDR_KEY_EDGE);
		end

		// Key 0 enabled and key 1 masked off
		write_reg(ADDR_KEY_MASK, 32'h5);
		read_reg(ADDR_KEY_MASK);
		press_key(1);
		press_key(0);
		// Clearing key 0 drops irq
		write_reg(ADDR_KEY_EDGE, 32'h1);
		read_reg(ADDR_KEY_EDGE);
		write_reg(ADDR_KEY_EDGE, 32'h2);
		read_reg(ADDR_KEY_EDGE);

		repeat (2) @(negedge clock_50);
		if (dut_i.assert_i.fail_count == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("Assertion failures were reported during the run");
			stop_run();
		end
	end

	// Stop at the first failed assertion
	always @(dut_i.assert_i.fail_count) begin
		if (dut_i.assert_i.fail_count != 0) begin
			$display("A concurrent assertion failed at %0t ns", $time);
			stop_run();
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		stop_run();
	end

endmodule

// ==== compile.f ====
hw/de1_io_pkg.sv
hw/board_input_sync.sv
hw/pio_regs.sv
hw/hex_display_drive.sv
hw/de1_io_system.sv
dv/de1_io_assert.sv
dv/tb_de1_io_system.sv
